// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := cache_bank_tb
FILELIST  := vlog.f

SRCS := $(wildcard hw/*.sv hw/*.svh bench/*.sv)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== bench/cache_bank_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_bank_tb;

    // 300 random requests at up to ~40 cycles each, plus the directed cases
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_REQS    = 300;
    localparam int EXP_W          = `CORE_TAG_BITS + `WORD_BITS;

    logic                  clk;
    logic                  rst_n;
    logic                  core_req_valid;
    logic                  core_req_rw;
    cache_pkg::line_addr_t core_req_addr;
    cache_pkg::wsel_t      core_req_wsel;
    cache_pkg::byteen_t    core_req_byteen;
    cache_pkg::word_t      core_req_data;
    cache_pkg::core_tag_t  core_req_tag;
    logic                  core_req_ready;
    logic                  core_rsp_valid;
    cache_pkg::word_t      core_rsp_data;
    cache_pkg::core_tag_t  core_rsp_tag;
    logic                  core_rsp_ready;
    logic                  mem_req_valid;
    logic                  mem_req_rw;
    cache_pkg::line_addr_t mem_req_addr;
    cache_pkg::wsel_t      mem_req_wsel;
    cache_pkg::byteen_t    mem_req_byteen;
    cache_pkg::word_t      mem_req_data;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    cache_pkg::line_t      mem_rsp_data;
    logic                  mem_rsp_ready;

    // reference copy of memory and the reads still owed a response
    cache_pkg::word_t      ref_mem [1 << `LINE_ADDR_BITS][`LINE_WORDS];
    logic [EXP_W-1:0]      exp_q [$];
    logic [EXP_W-1:0]      exp_head;

    string                 cur_test;
    logic                  rsp_throttle;
    int                    cycle_count;
    int                    writes_sent;
    int                    mem_reads_seen;
    int                    mem_writes_seen;
    int                    reads_before;
    logic                  last_rw;
    cache_pkg::line_addr_t last_addr;
    cache_pkg::wsel_t      last_wsel;
    cache_pkg::byteen_t    last_byteen;
    cache_pkg::word_t      last_data;

    cache_bank UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_rw      (mem_req_rw),
        .mem_req_addr    (mem_req_addr),
        .mem_req_wsel    (mem_req_wsel),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    mem_model backing_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (mem_req_valid),
        .req_rw     (mem_req_rw),
        .req_addr   (mem_req_addr),
        .req_wsel   (mem_req_wsel),
        .req_byteen (mem_req_byteen),
        .req_data   (mem_req_data),
        .req_ready  (mem_req_ready),
        .rsp_valid  (mem_rsp_valid),
        .rsp_data   (mem_rsp_data),
        .rsp_ready  (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run;
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_eq(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic send_req(input logic rw, input cache_pkg::line_addr_t addr,
                            input cache_pkg::wsel_t wsel, input cache_pkg::byteen_t byteen,
                            input cache_pkg::word_t data, input cache_pkg::core_tag_t tag);
        @(negedge clk);
        core_req_valid  = 1'b1;
        core_req_rw     = rw;
        core_req_addr   = addr;
        core_req_wsel   = wsel;
        core_req_byteen = byteen;
        core_req_data   = data;
        core_req_tag    = tag;
        do begin
            @(posedge clk);
        end while (!core_req_ready);
        if (rw) begin
            for (int b = 0; b < `WORD_BITS / 8; b++) begin
                if (byteen[b]) begin
                    ref_mem[addr][wsel][b*8 +: 8] = data[b*8 +: 8];
                end
            end
            writes_sent++;
        end else begin
            exp_q.push_back({tag, ref_mem[addr][wsel]});
        end
    endtask

    task automatic release_req;
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    // all reads answered and all writes seen at memory
    task automatic wait_quiet;
        do begin
            @(negedge clk);
        end while (exp_q.size() != 0 || mem_writes_seen != writes_sent);
    endtask

    task automatic check_last_mem_req(input logic rw, input cache_pkg::line_addr_t addr,
                                      input cache_pkg::wsel_t wsel,
                                      input cache_pkg::byteen_t byteen,
                                      input cache_pkg::word_t data);
        expect_eq("memory request rw", 32'(rw), 32'(last_rw));
        expect_eq("memory request address", 32'(addr), 32'(last_addr));
        if (rw) begin
            expect_eq("memory request wsel", 32'(wsel), 32'(last_wsel));
            expect_eq("memory request byteen", 32'(byteen), 32'(last_byteen));
            expect_eq("memory request data", data, last_data);
        end
    endtask

    task automatic check_idle_outputs;
        expect_eq("core_rsp_valid", 32'(0), 32'(core_rsp_valid));
        expect_eq("mem_req_valid", 32'(0), 32'(mem_req_valid));
        expect_eq("mem_rsp_ready", 32'(0), 32'(mem_rsp_ready));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in %s with %0d responses still due",
                     cycle_count, cur_test, exp_q.size());
            abort_run();
        end
    end

    always @(posedge clk) begin
        if (rst_n && core_rsp_valid && core_rsp_ready) begin
            assert (exp_q.size() != 0)
            else begin
                $display("Response with tag %h in %s arrived with no read outstanding",
                         core_rsp_tag, cur_test);
                abort_run();
            end
            exp_head = exp_q.pop_front();
            expect_eq("response tag", 32'(exp_head[`WORD_BITS +: `CORE_TAG_BITS]),
                      32'(core_rsp_tag));
            expect_eq("response data", exp_head[`WORD_BITS-1:0], core_rsp_data);
        end
    end

    always @(posedge clk) begin
        if (rst_n && mem_req_valid && mem_req_ready) begin
            last_rw     = mem_req_rw;
            last_addr   = mem_req_addr;
            last_wsel   = mem_req_wsel;
            last_byteen = mem_req_byteen;
            last_data   = mem_req_data;
            if (mem_req_rw) begin
                mem_writes_seen++;
            end else begin
                mem_reads_seen++;
            end
        end
    end

    // response back-pressure, random only in the mixed phase
    initial begin
        core_rsp_ready = 1'b1;
        forever begin
            @(negedge clk);
            core_rsp_ready = rsp_throttle ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    initial begin
        void'($urandom(23));
        rst_n           = 1'b0;
        core_req_valid  = 1'b0;
        core_req_rw     = 1'b0;
        core_req_addr   = '0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        rsp_throttle    = 1'b0;
        cycle_count     = 0;
        writes_sent     = 0;
        mem_reads_seen  = 0;
        mem_writes_seen = 0;
        for (int a = 0; a < (1 << `LINE_ADDR_BITS); a++) begin
            for (int w = 0; w < `LINE_WORDS; w++) begin
                ref_mem[a][w] = {22'(a), 10'(w)};
            end
        end

        cur_test = "reset";
        repeat (5) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        cur_test = "after reset";
        @(negedge clk);
        check_idle_outputs();
        expect_eq("core_req_ready", 32'(1), 32'(core_req_ready));

        cur_test = "read miss";
        reads_before = mem_reads_seen;
        send_req(1'b0, 10'h012, 2'd1, 4'hf, '0, 6'd1);
        release_req();
        wait_quiet();
        expect_eq("memory reads", reads_before + 1, mem_reads_seen);
        check_last_mem_req(1'b0, 10'h012, 2'd0, 4'h0, '0);

        cur_test = "read hit";
        reads_before = mem_reads_seen;
        send_req(1'b0, 10'h012, 2'd1, 4'hf, '0, 6'd2);
        release_req();
        wait_quiet();
        expect_eq("memory reads", reads_before, mem_reads_seen);

        cur_test = "write hit";
        reads_before = mem_reads_seen;
        send_req(1'b1, 10'h012, 2'd3, 4'b0101, 32'ha5c3_e17f, 6'd3);
        release_req();
        wait_quiet();
        check_last_mem_req(1'b1, 10'h012, 2'd3, 4'b0101, 32'ha5c3_e17f);
        send_req(1'b0, 10'h012, 2'd3, 4'hf, '0, 6'd4);
        release_req();
        wait_quiet();
        expect_eq("memory reads", reads_before, mem_reads_seen);

        cur_test = "write miss";
        reads_before = mem_reads_seen;
        send_req(1'b1, 10'h2b7, 2'd2, 4'b1100, 32'h1234_5678, 6'd5);
        release_req();
        wait_quiet();
        check_last_mem_req(1'b1, 10'h2b7, 2'd2, 4'b1100, 32'h1234_5678);
        send_req(1'b0, 10'h2b7, 2'd2, 4'hf, '0, 6'd6);
        release_req();
        wait_quiet();
        expect_eq("memory reads", reads_before + 1, mem_reads_seen);

        // 64 lines over 16 indexes gives both hits and conflict misses
        cur_test = "random mix";
        rsp_throttle = 1'b1;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            send_req(($urandom % 5) < 2, cache_pkg::line_addr_t'($urandom_range(0, 63)),
                     cache_pkg::wsel_t'($urandom % 4), cache_pkg::byteen_t'($urandom),
                     $urandom, cache_pkg::core_tag_t'(i));
        end
        release_req();
        rsp_throttle = 1'b0;
        wait_quiet();
        // nothing left queued once every read and write is accounted for
        check_idle_outputs();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module mem_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  logic                  req_rw,
    input  cache_pkg::line_addr_t req_addr,
    input  cache_pkg::wsel_t      req_wsel,
    input  cache_pkg::byteen_t    req_byteen,
    input  cache_pkg::word_t      req_data,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output cache_pkg::line_t      rsp_data,
    input  logic                  rsp_ready
);

    cache_pkg::word_t      mem [1 << `LINE_ADDR_BITS][`LINE_WORDS];
    logic                  pending;
    logic                  rsp_taken;
    int unsigned           delay;
    cache_pkg::line_addr_t read_addr;

    // word w of line a starts out as {a, w}
    initial begin
        for (int a = 0; a < (1 << `LINE_ADDR_BITS); a++) begin
            for (int w = 0; w < `LINE_WORDS; w++) begin
                mem[a][w] = {22'(a), 10'(w)};
            end
        end
    end

    // sample handshakes on the rising edge, drive on the falling edge
    initial begin
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        pending   = 1'b0;
        rsp_taken = 1'b0;
        delay     = 0;
        read_addr = '0;
        forever begin
            @(posedge clk);
            rsp_taken = rsp_valid && rsp_ready;
            if (req_valid && req_ready) begin
                if (req_rw) begin
                    for (int b = 0; b < `WORD_BITS / 8; b++) begin
                        if (req_byteen[b]) begin
                            mem[req_addr][req_wsel][b*8 +: 8] = req_data[b*8 +: 8];
                        end
                    end
                end else begin
                    pending   = 1'b1;
                    read_addr = req_addr;
                    delay     = $urandom % 8;
                end
            end
            @(negedge clk);
            if (rsp_taken) begin
                rsp_valid = 1'b0;
                pending   = 1'b0;
            end
            if (pending && !rsp_valid) begin
                if (delay == 0) begin
                    rsp_valid = 1'b1;
                    for (int w = 0; w < `LINE_WORDS; w++) begin
                        rsp_data[w*`WORD_BITS +: `WORD_BITS] = mem[read_addr][w];
                    end
                end else begin
                    delay--;
                end
            end
            // one read at a time, so no new request while a line is due
            req_ready = rst_n && !pending && (($urandom % 4) != 0);
        end
    end

endmodule

`default_nettype wire

// ==== hw/bank_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module bank_fifo #(
    parameter int WIDTH    = 8,
    parameter int DEPTH    = 4,
    parameter int ALM_FREE = 0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    input  logic             pop,
    output logic [WIDTH-1:0] data_out,
    output logic             empty,
    output logic             alm_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // head entry read straight from storage
    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);

    // raised once free slots drop to ALM_FREE
    assign alm_full = (count >= CNT_W'(DEPTH - ALM_FREE));

endmodule

`default_nettype wire

// ==== hw/cache_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_bank (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  core_req_valid,
    input  logic                  core_req_rw,
    input  cache_pkg::line_addr_t core_req_addr,
    input  cache_pkg::wsel_t      core_req_wsel,
    input  cache_pkg::byteen_t    core_req_byteen,
    input  cache_pkg::word_t      core_req_data,
    input  cache_pkg::core_tag_t  core_req_tag,
    output logic                  core_req_ready,

    output logic                  core_rsp_valid,
    output cache_pkg::word_t      core_rsp_data,
    output cache_pkg::core_tag_t  core_rsp_tag,
    input  logic                  core_rsp_ready,

    output logic                  mem_req_valid,
    output logic                  mem_req_rw,
    output cache_pkg::line_addr_t mem_req_addr,
    output cache_pkg::wsel_t      mem_req_wsel,
    output cache_pkg::byteen_t    mem_req_byteen,
    output cache_pkg::word_t      mem_req_data,
    input  logic                  mem_req_ready,

    input  logic                  mem_rsp_valid,
    input  cache_pkg::line_t      mem_rsp_data,
    output logic                  mem_rsp_ready
);

    localparam int CREQ_W = 1 + $bits(cache_pkg::line_addr_t) + $bits(cache_pkg::wsel_t)
                          + $bits(cache_pkg::byteen_t) + $bits(cache_pkg::word_t)
                          + $bits(cache_pkg::core_tag_t);
    localparam int CRSP_W = $bits(cache_pkg::word_t) + $bits(cache_pkg::core_tag_t);
    localparam int MREQ_W = 1 + $bits(cache_pkg::line_addr_t) + $bits(cache_pkg::wsel_t)
                          + $bits(cache_pkg::byteen_t) + $bits(cache_pkg::word_t);

    logic                  creq_empty;
    logic                  creq_full;
    logic                  creq_rw;
    cache_pkg::line_addr_t creq_addr;
    cache_pkg::wsel_t      creq_wsel;
    cache_pkg::byteen_t    creq_byteen;
    cache_pkg::word_t      creq_data;
    cache_pkg::core_tag_t  creq_tag;

    logic                  miss_busy;
    logic                  miss_waiting;
    logic                  replay_valid;
    cache_pkg::line_addr_t miss_addr;
    cache_pkg::wsel_t      miss_wsel;
    cache_pkg::core_tag_t  miss_tag;

    logic                  replay_issue;
    logic                  fill_issue;
    logic                  creq_issue;
    logic                  crsq_alm_full;
    logic                  mreq_alm_full;
    logic                  crsq_empty;
    logic                  mreq_empty;

    cache_pkg::line_addr_t addr_stinit;
    cache_pkg::wsel_t      wsel_stinit;
    cache_pkg::core_tag_t  tag_stinit;

    logic                  is_read_st0;
    logic                  is_write_st0;
    logic                  is_fill_st0;
    logic                  is_replay_st0;
    logic                  st0_busy;
    logic                  hit_st0;
    logic                  write_hit_st0;
    cache_pkg::line_addr_t addr_st0;
    cache_pkg::wsel_t      wsel_st0;
    cache_pkg::byteen_t    byteen_st0;
    cache_pkg::word_t      wdata_st0;
    cache_pkg::core_tag_t  tag_st0;
    cache_pkg::line_t      fill_data_st0;
    cache_pkg::word_t      rdata_st0;
    cache_pkg::index_t     data_index;
    cache_pkg::wsel_t      data_wsel;

    logic                  rsp_st1;
    logic                  mreq_st1;
    logic                  rw_st1;
    cache_pkg::line_addr_t addr_st1;
    cache_pkg::wsel_t      wsel_st1;
    cache_pkg::byteen_t    byteen_st1;
    cache_pkg::word_t      wdata_st1;
    cache_pkg::core_tag_t  tag_st1;
    cache_pkg::word_t      rdata_st1;

    assign core_req_ready = ~creq_full;

    bank_fifo #(
        .WIDTH    (CREQ_W),
        .DEPTH    (`QUEUE_DEPTH),
        .ALM_FREE (0)
    ) core_req_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (core_req_valid && core_req_ready),
        .data_in  ({core_req_rw, core_req_addr, core_req_wsel, core_req_byteen,
                    core_req_data, core_req_tag}),
        .pop      (creq_issue),
        .data_out ({creq_rw, creq_addr, creq_wsel, creq_byteen, creq_data, creq_tag}),
        .empty    (creq_empty),
        .alm_full (creq_full)
    );

    // issue priority: replay, fill, core request
    // replay and fill come from exclusive miss states, so they never collide
    assign replay_issue  = replay_valid && !is_fill_st0;
    assign fill_issue    = miss_waiting && mem_rsp_valid;
    assign mem_rsp_ready = fill_issue;

    // no read or write may issue next to a store update in st0
    assign st0_busy   = is_read_st0 || is_write_st0 || is_fill_st0;
    assign creq_issue = !creq_empty && !replay_issue && !fill_issue && !miss_busy
                     && !st0_busy && !crsq_alm_full && !mreq_alm_full;

    assign addr_stinit = creq_issue ? creq_addr : miss_addr;
    assign wsel_stinit = creq_issue ? creq_wsel : miss_wsel;
    assign tag_stinit  = creq_issue ? creq_tag  : miss_tag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_read_st0   <= 1'b0;
            is_write_st0  <= 1'b0;
            is_fill_st0   <= 1'b0;
            is_replay_st0 <= 1'b0;
        end else begin
            is_read_st0   <= creq_issue && !creq_rw;
            is_write_st0  <= creq_issue && creq_rw;
            is_fill_st0   <= fill_issue;
            is_replay_st0 <= replay_issue;
        end
    end

    always_ff @(posedge clk) begin
        addr_st0      <= addr_stinit;
        wsel_st0      <= wsel_stinit;
        tag_st0       <= tag_stinit;
        byteen_st0    <= creq_byteen;
        wdata_st0     <= creq_data;
        fill_data_st0 <= mem_rsp_data;
    end

    // tags are filled at issue, so the replay right behind sees them
    tag_store tags (
        .clk    (clk),
        .rst_n  (rst_n),
        .lookup (creq_issue || replay_issue),
        .fill   (fill_issue),
        .addr   (addr_stinit),
        .hit    (hit_st0)
    );

    assign write_hit_st0 = is_write_st0 && hit_st0;

    // reads index from stinit, updates from st0
    assign data_index = (write_hit_st0 || is_fill_st0) ? addr_st0[`INDEX_BITS-1:0]
                                                        : addr_stinit[`INDEX_BITS-1:0];
    assign data_wsel  = write_hit_st0 ? wsel_st0 : wsel_stinit;

    data_store data (
        .clk        (clk),
        .read       (replay_issue || (creq_issue && !creq_rw)),
        .write      (write_hit_st0),
        .fill       (is_fill_st0),
        .index      (data_index),
        .wsel       (data_wsel),
        .byteen     (byteen_st0),
        .write_data (wdata_st0),
        .fill_data  (fill_data_st0),
        .read_data  (rdata_st0)
    );

    miss_entry miss (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (is_read_st0 && !hit_st0),
        .alloc_addr   (addr_st0),
        .alloc_wsel   (wsel_st0),
        .alloc_tag    (tag_st0),
        .fill_issue   (fill_issue),
        .replay_take  (replay_issue),
        .busy         (miss_busy),
        .waiting      (miss_waiting),
        .replay_valid (replay_valid),
        .replay_addr  (miss_addr),
        .replay_wsel  (miss_wsel),
        .replay_tag   (miss_tag)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_st1  <= 1'b0;
            mreq_st1 <= 1'b0;
        end else begin
            rsp_st1  <= (is_read_st0 && hit_st0) || is_replay_st0;
            // write-through for every write, line fetch for a read miss
            mreq_st1 <= is_write_st0 || (is_read_st0 && !hit_st0);
        end
    end

    always_ff @(posedge clk) begin
        rw_st1     <= is_write_st0;
        addr_st1   <= addr_st0;
        wsel_st1   <= wsel_st0;
        byteen_st1 <= byteen_st0;
        wdata_st1  <= wdata_st0;
        tag_st1    <= tag_st0;
        rdata_st1  <= rdata_st0;
    end

    bank_fifo #(
        .WIDTH    (CRSP_W),
        .DEPTH    (`QUEUE_DEPTH),
        .ALM_FREE (2)
    ) core_rsp_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (rsp_st1),
        .data_in  ({rdata_st1, tag_st1}),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_out ({core_rsp_data, core_rsp_tag}),
        .empty    (crsq_empty),
        .alm_full (crsq_alm_full)
    );

    assign core_rsp_valid = ~crsq_empty;

    bank_fifo #(
        .WIDTH    (MREQ_W),
        .DEPTH    (`QUEUE_DEPTH),
        .ALM_FREE (2)
    ) mem_req_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (mreq_st1),
        .data_in  ({rw_st1, addr_st1, wsel_st1, byteen_st1, wdata_st1}),
        .pop      (mem_req_valid && mem_req_ready),
        .data_out ({mem_req_rw, mem_req_addr, mem_req_wsel, mem_req_byteen, mem_req_data}),
        .empty    (mreq_empty),
        .alm_full (mreq_alm_full)
    );

    assign mem_req_valid = ~mreq_empty;

endmodule

`default_nettype wire

// ==== hw/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// data word and line geometry
`define WORD_BITS       32
`define LINE_WORDS      4

// line address splits into tag and index
`define LINE_ADDR_BITS  10
`define INDEX_BITS      4

`define CORE_TAG_BITS   6

// all three bank queues share this depth
`define QUEUE_DEPTH     4

`endif

// ==== hw/cache_pkg.sv ====
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    typedef logic [`WORD_BITS-1:0]                  word_t;
    typedef logic [`WORD_BITS/8-1:0]                byteen_t;

    // word offset inside a line
    typedef logic [$clog2(`LINE_WORDS)-1:0]         wsel_t;

    // word w sits at bits [w*WORD_BITS +: WORD_BITS]
    typedef logic [`LINE_WORDS*`WORD_BITS-1:0]      line_t;

    typedef logic [`LINE_ADDR_BITS-1:0]             line_addr_t;
    typedef logic [`INDEX_BITS-1:0]                 index_t;

    // upper line address bits above the index
    typedef logic [`LINE_ADDR_BITS-`INDEX_BITS-1:0] tag_t;

    typedef logic [`CORE_TAG_BITS-1:0]              core_tag_t;

endpackage

`default_nettype wire

// ==== hw/data_store.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module data_store (
    input  logic              clk,
    input  logic              read,
    input  logic              write,
    input  logic              fill,
    input  cache_pkg::index_t index,
    input  cache_pkg::wsel_t  wsel,
    input  cache_pkg::byteen_t byteen,
    input  cache_pkg::word_t  write_data,
    input  cache_pkg::line_t  fill_data,
    output cache_pkg::word_t  read_data
);

    localparam int LINES = 1 << `INDEX_BITS;
    localparam int BYTES = `WORD_BITS / 8;

    cache_pkg::word_t mem [LINES][`LINE_WORDS];

    always_ff @(posedge clk) begin
        if (fill) begin
            // whole line from the memory response
            for (int w = 0; w < `LINE_WORDS; w++) begin
                mem[index][w] <= fill_data[w*`WORD_BITS +: `WORD_BITS];
            end
        end else if (write) begin
            for (int b = 0; b < BYTES; b++) begin
                if (byteen[b]) begin
                    mem[index][wsel][b*8 +: 8] <= write_data[b*8 +: 8];
                end
            end
        end
    end

    // word comes out one cycle after the read strobe
    always_ff @(posedge clk) begin
        if (read) begin
            read_data <= mem[index][wsel];
        end
    end

endmodule

`default_nettype wire

// ==== hw/miss_entry.sv ====
`default_nettype none
`timescale 1ns/1ps

module miss_entry (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc,
    input  cache_pkg::line_addr_t alloc_addr,
    input  cache_pkg::wsel_t      alloc_wsel,
    input  cache_pkg::core_tag_t  alloc_tag,
    input  logic                  fill_issue,
    input  logic                  replay_take,
    output logic                  busy,
    output logic                  waiting,
    output logic                  replay_valid,
    output cache_pkg::line_addr_t replay_addr,
    output cache_pkg::wsel_t      replay_wsel,
    output cache_pkg::core_tag_t  replay_tag
);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_WAIT   = 2'd1;
    localparam logic [1:0] S_REPLAY = 2'd2;

    logic [1:0] state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:   if (alloc) state <= S_WAIT;
                S_WAIT:   if (fill_issue) state <= S_REPLAY;
                S_REPLAY: if (replay_take) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // the missed read, kept until its replay
    always_ff @(posedge clk) begin
        if (alloc && (state == S_IDLE)) begin
            replay_addr <= alloc_addr;
            replay_wsel <= alloc_wsel;
            replay_tag  <= alloc_tag;
        end
    end

    assign busy         = (state != S_IDLE);
    assign waiting      = (state == S_WAIT);
    assign replay_valid = (state == S_REPLAY);

endmodule

`default_nettype wire

// ==== hw/tag_store.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module tag_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  lookup,
    input  logic                  fill,
    input  cache_pkg::line_addr_t addr,
    output logic                  hit
);

    localparam int LINES = 1 << `INDEX_BITS;

    logic [LINES-1:0]  valid_q;
    cache_pkg::tag_t   tags [LINES];

    cache_pkg::index_t index_in;
    cache_pkg::tag_t   tag_in;
    cache_pkg::index_t index_q;
    cache_pkg::tag_t   tag_q;

    assign index_in = addr[`INDEX_BITS-1:0];
    assign tag_in   = addr[`LINE_ADDR_BITS-1:`INDEX_BITS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[index_in] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index_in] <= tag_in;
        end
    end

    // hold the looked-up address for the st0 compare
    always_ff @(posedge clk) begin
        if (lookup) begin
            index_q <= index_in;
            tag_q   <= tag_in;
        end
    end

    assign hit = valid_q[index_q] && (tags[index_q] == tag_q);

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/cache_pkg.sv
hw/bank_fifo.sv
hw/tag_store.sv
hw/data_store.sv
hw/miss_entry.sv
hw/cache_bank.sv
bench/mem_model.sv
bench/cache_bank_tb.sv
